//--- hw/stq_params.svh
`ifndef STQ_PARAMS_SVH
`define STQ_PARAMS_SVH

// queue depth and index width go together
`define STQ_DEPTH 16
`define STQ_IDX_W 4

// word address, byte lanes per word
`define STQ_ADDR_W 30
`define STQ_DATA_W 32
`define STQ_BE_W 4

`endif

//--- hw/stq_pkg.sv
`include "stq_params.svh"

package stq_pkg;

  typedef logic [`STQ_IDX_W-1:0] stq_idx_t;

  // msb is the wrap bit
  typedef logic [`STQ_IDX_W:0] stq_ptr_t;

  typedef logic [`STQ_ADDR_W-1:0] stq_addr_t;
  typedef logic [`STQ_DATA_W-1:0] stq_data_t;
  typedef logic [`STQ_BE_W-1:0] stq_be_t;

  // one bit per entry
  typedef logic [`STQ_DEPTH-1:0] stq_mask_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    FENCE_ACK
  } drain_state_t;

endpackage

//--- hw/stq_ptr_ctr.sv
`timescale 1ns/100ps

`include "stq_params.svh"

module stq_ptr_ctr (
  input  logic              clk,
  input  logic              rst,
  input  logic              alloc_en,
  input  logic              commit_en,
  input  logic              free_en,
  input  logic              excpt,
  output stq_pkg::stq_ptr_t head_ptr,
  output stq_pkg::stq_ptr_t commit_ptr,
  output stq_pkg::stq_ptr_t tail_ptr,
  output logic              alloc_rdy,
  output logic              empty,
  output logic              drain_pending
);

  logic full;
  logic do_alloc;
  logic do_commit;

  // same slot, opposite lap
  assign full = (tail_ptr == {~head_ptr[`STQ_IDX_W], head_ptr[`STQ_IDX_W-1:0]});
  assign empty = (head_ptr == tail_ptr);
  assign drain_pending = (head_ptr != commit_ptr); // committed, not yet written back

  assign alloc_rdy = ~full;

  assign do_alloc = alloc_en & alloc_rdy & ~excpt;
  assign do_commit = commit_en & ~excpt & (commit_ptr != tail_ptr);

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      commit_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      if (free_en) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (do_commit) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
      if (excpt) begin
        tail_ptr <= commit_ptr; // drop everything past commit
      end else if (do_alloc) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
    end
  end

endmodule

//--- hw/stq_drain_fsm.sv
`timescale 1ns/100ps

module stq_drain_fsm (
  input  logic clk,
  input  logic rst,
  input  logic drain_pending,
  input  logic empty,
  input  logic wb_ready,
  input  logic fence_req,
  output logic wb_valid,
  output logic free_en,
  output logic fence_done
);

  stq_pkg::drain_state_t state;
  stq_pkg::drain_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      stq_pkg::IDLE: begin
        if (drain_pending) begin
          state_nxt = stq_pkg::SEND;
        end else if (fence_req && empty) begin
          state_nxt = stq_pkg::FENCE_ACK;
        end
      end
      stq_pkg::SEND: begin
        // hold until the write-back port takes it
        if (wb_ready) begin
          state_nxt = stq_pkg::IDLE;
        end
      end
      stq_pkg::FENCE_ACK: begin
        state_nxt = stq_pkg::IDLE; // single cycle ack
      end
      default: begin
        state_nxt = stq_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stq_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign wb_valid = (state == stq_pkg::SEND);
  assign free_en = wb_valid & wb_ready; // transfer frees the head entry
  assign fence_done = (state == stq_pkg::FENCE_ACK);

endmodule

//--- hw/stq_addr_cam.sv
`timescale 1ns/100ps

`include "stq_params.svh"

module stq_addr_cam (
  input  logic               clk,
  input  logic               rst,
  input  logic               excpt,
  input  logic               wrt_en,
  input  stq_pkg::stq_idx_t  wrt_idx,
  input  stq_pkg::stq_addr_t wrt_addr,
  input  stq_pkg::stq_be_t   wrt_be,
  input  logic               upd_en,
  input  stq_pkg::stq_idx_t  upd_idx,
  input  stq_pkg::stq_addr_t chk_addr,
  input  stq_pkg::stq_be_t   chk_be,
  input  stq_pkg::stq_ptr_t  commit_ptr,
  input  stq_pkg::stq_ptr_t  tail_ptr,
  input  stq_pkg::stq_ptr_t  head_ptr,
  input  logic               free_en,
  output stq_pkg::stq_mask_t overlap,
  output stq_pkg::stq_mask_t covered,
  output stq_pkg::stq_mask_t data_ok,
  output stq_pkg::stq_addr_t head_addr,
  output stq_pkg::stq_be_t   head_be
);

  stq_pkg::stq_addr_t addr_q [`STQ_DEPTH];
  stq_pkg::stq_be_t   be_q [`STQ_DEPTH];
  stq_pkg::stq_mask_t addr_ok;
  stq_pkg::stq_mask_t flush_mask;
  stq_pkg::stq_ptr_t  flush_cnt;

  // uncommitted entries, commit up to tail
  assign flush_cnt = tail_ptr - commit_ptr;

  genvar i;
  generate
    for (i = 0; i < `STQ_DEPTH; i++) begin : g_ent
      stq_pkg::stq_idx_t off;
      stq_pkg::stq_be_t  both;

      assign off = stq_pkg::stq_idx_t'(i) - commit_ptr[`STQ_IDX_W-1:0];
      assign flush_mask[i] = ({1'b0, off} < flush_cnt);

      assign both = be_q[i] & chk_be;
      assign overlap[i] = addr_ok[i] && (addr_q[i] == chk_addr) && (|both);
      assign covered[i] = overlap[i] && (both == chk_be);
    end
  endgenerate

  // address array, written once per entry
  always_ff @(posedge clk) begin
    if (wrt_en && !excpt) begin
      addr_q[wrt_idx] <= wrt_addr;
      be_q[wrt_idx] <= wrt_be;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      addr_ok <= '0;
      data_ok <= '0;
    end else begin
      for (int k = 0; k < `STQ_DEPTH; k++) begin
        if (excpt && flush_mask[k]) begin
          addr_ok[k] <= 1'b0;
          data_ok[k] <= 1'b0;
        end else if (free_en && (head_ptr[`STQ_IDX_W-1:0] == stq_pkg::stq_idx_t'(k))) begin
          addr_ok[k] <= 1'b0;
          data_ok[k] <= 1'b0;
        end else if (!excpt) begin
          if (wrt_en && (wrt_idx == stq_pkg::stq_idx_t'(k))) begin
            addr_ok[k] <= 1'b1;
          end
          if (upd_en && (upd_idx == stq_pkg::stq_idx_t'(k))) begin
            data_ok[k] <= 1'b1;
          end
        end
      end
    end
  end

  assign head_addr = addr_q[head_ptr[`STQ_IDX_W-1:0]];
  assign head_be = be_q[head_ptr[`STQ_IDX_W-1:0]];

endmodule

//--- hw/stq_data_ram.sv
`timescale 1ns/100ps

`include "stq_params.svh"

module stq_data_ram (
  input  logic               clk,
  input  logic               upd_en,
  input  stq_pkg::stq_idx_t  upd_idx,
  input  stq_pkg::stq_data_t upd_data,
  input  stq_pkg::stq_idx_t  fwd_idx,
  input  stq_pkg::stq_idx_t  head_idx,
  output stq_pkg::stq_data_t fwd_rd_data,
  output stq_pkg::stq_data_t head_data
);

  stq_pkg::stq_data_t mem [`STQ_DEPTH];

  always_ff @(posedge clk) begin
    if (upd_en) begin
      mem[upd_idx] <= upd_data;
    end
  end

  // forward read for loads, head read for write-back
  assign fwd_rd_data = mem[fwd_idx];
  assign head_data = mem[head_idx];

endmodule

//--- hw/stq_fwd_select.sv
`timescale 1ns/100ps

`include "stq_params.svh"

module stq_fwd_select (
  input  logic               clk,
  input  logic               rst,
  input  logic               chk_en,
  input  stq_pkg::stq_ptr_t  chk_ptr,
  input  stq_pkg::stq_ptr_t  head_ptr,
  input  stq_pkg::stq_mask_t overlap,
  input  stq_pkg::stq_mask_t covered,
  input  stq_pkg::stq_mask_t data_ok,
  input  stq_pkg::stq_data_t fwd_rd_data,
  output stq_pkg::stq_idx_t  fwd_idx,
  output logic               fwd_valid,
  output logic               fwd_hit,
  output logic               fwd_partial,
  output stq_pkg::stq_data_t fwd_data
);

  stq_pkg::stq_ptr_t raw_cnt;
  stq_pkg::stq_ptr_t win_cnt;
  logic              found;
  logic              hit;

  assign raw_cnt = chk_ptr - head_ptr;
  // head already past the load's tail, nothing older is left
  assign win_cnt = (raw_cnt[`STQ_IDX_W] && (|raw_cnt[`STQ_IDX_W-1:0])) ? '0 : raw_cnt;

  // walk from head towards the load, last match is the youngest
  always_comb begin
    stq_pkg::stq_idx_t idx;
    found = 1'b0;
    fwd_idx = head_ptr[`STQ_IDX_W-1:0];
    for (int k = 0; k < `STQ_DEPTH; k++) begin
      idx = head_ptr[`STQ_IDX_W-1:0] + stq_pkg::stq_idx_t'(k);
      if (({1'b0, stq_pkg::stq_idx_t'(k)} < win_cnt) && overlap[idx]) begin
        found = 1'b1;
        fwd_idx = idx;
      end
    end
  end

  assign hit = found && covered[fwd_idx] && data_ok[fwd_idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_valid <= 1'b0;
      fwd_hit <= 1'b0;
      fwd_partial <= 1'b0;
    end else begin
      fwd_valid <= chk_en;
      fwd_hit <= chk_en && hit;
      fwd_partial <= chk_en && found && !hit; // load has to wait
    end
  end

  always_ff @(posedge clk) begin
    fwd_data <= (chk_en && hit) ? fwd_rd_data : '0;
  end

endmodule

//--- hw/stq_top.sv
`timescale 1ns/100ps

`include "stq_params.svh"

module stq_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               alloc_en,
  output logic               alloc_rdy,
  output stq_pkg::stq_ptr_t  alloc_ptr,
  input  logic               wrt_en,
  input  stq_pkg::stq_idx_t  wrt_idx,
  input  stq_pkg::stq_addr_t wrt_addr,
  input  stq_pkg::stq_be_t   wrt_be,
  input  logic               upd_en,
  input  stq_pkg::stq_idx_t  upd_idx,
  input  stq_pkg::stq_data_t upd_data,
  input  logic               chk_en,
  input  stq_pkg::stq_addr_t chk_addr,
  input  stq_pkg::stq_be_t   chk_be,
  input  stq_pkg::stq_ptr_t  chk_ptr,
  output logic               fwd_valid,
  output logic               fwd_hit,
  output logic               fwd_partial,
  output stq_pkg::stq_data_t fwd_data,
  input  logic               commit_en,
  output logic               wb_valid,
  output stq_pkg::stq_addr_t wb_addr,
  output stq_pkg::stq_be_t   wb_be,
  output stq_pkg::stq_data_t wb_data,
  input  logic               wb_ready,
  input  logic               excpt,
  input  logic               fence_req,
  output logic               fence_done
);

  stq_pkg::stq_ptr_t  head_ptr;
  stq_pkg::stq_ptr_t  commit_ptr;
  logic               empty;
  logic               drain_pending;
  logic               free_en;
  stq_pkg::stq_mask_t overlap;
  stq_pkg::stq_mask_t covered;
  stq_pkg::stq_mask_t data_ok;
  stq_pkg::stq_idx_t  fwd_idx;
  stq_pkg::stq_data_t fwd_rd_data;

  // tail pointer doubles as the allocation index
  stq_ptr_ctr i_ptr_ctr (
    .clk           (clk),
    .rst           (rst),
    .alloc_en      (alloc_en),
    .commit_en     (commit_en),
    .free_en       (free_en),
    .excpt         (excpt),
    .head_ptr      (head_ptr),
    .commit_ptr    (commit_ptr),
    .tail_ptr      (alloc_ptr),
    .alloc_rdy     (alloc_rdy),
    .empty         (empty),
    .drain_pending (drain_pending)
  );

  stq_drain_fsm i_drain_fsm (
    .clk           (clk),
    .rst           (rst),
    .drain_pending (drain_pending),
    .empty         (empty),
    .wb_ready      (wb_ready),
    .fence_req     (fence_req),
    .wb_valid      (wb_valid),
    .free_en       (free_en),
    .fence_done    (fence_done)
  );

  stq_addr_cam i_addr_cam (
    .clk        (clk),
    .rst        (rst),
    .excpt      (excpt),
    .wrt_en     (wrt_en),
    .wrt_idx    (wrt_idx),
    .wrt_addr   (wrt_addr),
    .wrt_be     (wrt_be),
    .upd_en     (upd_en),
    .upd_idx    (upd_idx),
    .chk_addr   (chk_addr),
    .chk_be     (chk_be),
    .commit_ptr (commit_ptr),
    .tail_ptr   (alloc_ptr),
    .head_ptr   (head_ptr),
    .free_en    (free_en),
    .overlap    (overlap),
    .covered    (covered),
    .data_ok    (data_ok),
    .head_addr  (wb_addr),
    .head_be    (wb_be)
  );

  stq_data_ram i_data_ram (
    .clk         (clk),
    .upd_en      (upd_en & ~excpt), // no data write on a flush edge
    .upd_idx     (upd_idx),
    .upd_data    (upd_data),
    .fwd_idx     (fwd_idx),
    .head_idx    (head_ptr[`STQ_IDX_W-1:0]),
    .fwd_rd_data (fwd_rd_data),
    .head_data   (wb_data)
  );

  stq_fwd_select i_fwd_select (
    .clk         (clk),
    .rst         (rst),
    .chk_en      (chk_en),
    .chk_ptr     (chk_ptr),
    .head_ptr    (head_ptr),
    .overlap     (overlap),
    .covered     (covered),
    .data_ok     (data_ok),
    .fwd_rd_data (fwd_rd_data),
    .fwd_idx     (fwd_idx),
    .fwd_valid   (fwd_valid),
    .fwd_hit     (fwd_hit),
    .fwd_partial (fwd_partial),
    .fwd_data    (fwd_data)
  );

endmodule

//--- verif/stq_tb.sv
`timescale 1ns/100ps

`include "stq_params.svh"

module stq_tb;

  localparam logic [3:0] op_alloc = 4'd0;
  localparam logic [3:0] op_wrt = 4'd1;
  localparam logic [3:0] op_upd = 4'd2;
  localparam logic [3:0] op_commit = 4'd3;
  localparam logic [3:0] op_chk = 4'd4;
  localparam logic [3:0] op_excpt = 4'd5;
  localparam logic [3:0] op_fence = 4'd6;
  localparam logic [3:0] op_rdy = 4'd7;
  localparam logic [3:0] op_wait = 4'd8;
  localparam logic [7:0] none = 8'hff; // no store, or the current tail for chk_ptr

  typedef struct packed {
    logic [3:0]         op;
    logic [7:0]         sid;   // store number, in allocation order
    stq_pkg::stq_addr_t addr;
    stq_pkg::stq_be_t   be;
    stq_pkg::stq_data_t data;  // zero takes lfsr data
    logic [7:0]         psid;  // load dispatched before this store
    logic               eh;
    logic               ep;
    logic [7:0]         esid;  // store whose data forwards
  } row_t;

  logic               clk;
  logic               rst;
  logic               alloc_en;
  logic               alloc_rdy;
  stq_pkg::stq_ptr_t  alloc_ptr;
  logic               wrt_en;
  stq_pkg::stq_idx_t  wrt_idx;
  stq_pkg::stq_addr_t wrt_addr;
  stq_pkg::stq_be_t   wrt_be;
  logic               upd_en;
  stq_pkg::stq_idx_t  upd_idx;
  stq_pkg::stq_data_t upd_data;
  logic               chk_en;
  stq_pkg::stq_addr_t chk_addr;
  stq_pkg::stq_be_t   chk_be;
  stq_pkg::stq_ptr_t  chk_ptr;
  logic               fwd_valid;
  logic               fwd_hit;
  logic               fwd_partial;
  stq_pkg::stq_data_t fwd_data;
  logic               commit_en;
  logic               wb_valid;
  stq_pkg::stq_addr_t wb_addr;
  stq_pkg::stq_be_t   wb_be;
  stq_pkg::stq_data_t wb_data;
  logic               wb_ready;
  logic               excpt;
  logic               fence_req;
  logic               fence_done;

  row_t               rows[$];
  stq_pkg::stq_ptr_t  st_ptr [32];
  stq_pkg::stq_addr_t st_addr [32];
  stq_pkg::stq_be_t   st_be [32];
  stq_pkg::stq_data_t st_data [32];
  int                 pend_q[$]; // allocated, not committed
  int                 wb_q[$];   // committed, not drained
  int                 due_q[$];
  logic               exp_hit_q[$];
  logic               exp_part_q[$];
  stq_pkg::stq_data_t exp_data_q[$];
  stq_pkg::stq_ptr_t  m_tail;
  stq_pkg::stq_ptr_t  m_commit;
  logic               held;
  stq_pkg::stq_addr_t held_addr;
  stq_pkg::stq_be_t   held_be;
  stq_pkg::stq_data_t held_data;
  logic [15:0]        lfsr;
  int                 cyc = 0;
  int                 limit = 0;
  int                 n_mismatch = 0;
  int                 n_other = 0;

  stq_top i_stq_top (
    .clk         (clk),
    .rst         (rst),
    .alloc_en    (alloc_en),
    .alloc_rdy   (alloc_rdy),
    .alloc_ptr   (alloc_ptr),
    .wrt_en      (wrt_en),
    .wrt_idx     (wrt_idx),
    .wrt_addr    (wrt_addr),
    .wrt_be      (wrt_be),
    .upd_en      (upd_en),
    .upd_idx     (upd_idx),
    .upd_data    (upd_data),
    .chk_en      (chk_en),
    .chk_addr    (chk_addr),
    .chk_be      (chk_be),
    .chk_ptr     (chk_ptr),
    .fwd_valid   (fwd_valid),
    .fwd_hit     (fwd_hit),
    .fwd_partial (fwd_partial),
    .fwd_data    (fwd_data),
    .commit_en   (commit_en),
    .wb_valid    (wb_valid),
    .wb_addr     (wb_addr),
    .wb_be       (wb_be),
    .wb_data     (wb_data),
    .wb_ready    (wb_ready),
    .excpt       (excpt),
    .fence_req   (fence_req),
    .fence_done  (fence_done)
  );

  initial begin
    clk = 1'b0;
  end

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic logic_compare(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic data_compare(input string name, input stq_pkg::stq_data_t got,
                              input stq_pkg::stq_data_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic addr_compare(input string name, input stq_pkg::stq_addr_t got,
                              input stq_pkg::stq_addr_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic be_compare(input string name, input stq_pkg::stq_be_t got,
                            input stq_pkg::stq_be_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic ptr_compare(input string name, input stq_pkg::stq_ptr_t got,
                             input stq_pkg::stq_ptr_t exp);
    if (got !== exp) begin
      n_mismatch++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic add_row(input logic [3:0] op, input logic [7:0] sid,
                         input stq_pkg::stq_addr_t addr, input stq_pkg::stq_be_t be,
                         input stq_pkg::stq_data_t data, input logic [7:0] psid,
                         input logic eh, input logic ep, input logic [7:0] esid);
    row_t r;
    r.op = op;
    r.sid = sid;
    r.addr = addr;
    r.be = be;
    r.data = data;
    r.psid = psid;
    r.eh = eh;
    r.ep = ep;
    r.esid = esid;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // forwarding among s0..s3
    for (int k = 0; k < 4; k++) begin
      add_row(op_alloc, 8'(k), '0, '0, '0, none, 0, 0, none);
    end
    add_row(op_wrt, 0, 30'h100, 4'hf, '0, none, 0, 0, none);
    add_row(op_upd, 0, '0, '0, '0, none, 0, 0, none);
    add_row(op_wrt, 1, 30'h100, 4'hf, '0, none, 0, 0, none);
    add_row(op_upd, 1, '0, '0, 32'h1357_9bdf, none, 0, 0, none);
    add_row(op_chk, none, 30'h100, 4'hf, '0, none, 1, 0, 1); // younger store wins
    add_row(op_chk, none, 30'h100, 4'h3, '0, 1, 1, 0, 0);
    add_row(op_wrt, 2, 30'h200, 4'h3, '0, none, 0, 0, none);
    add_row(op_chk, none, 30'h200, 4'h3, '0, none, 0, 1, none); // data not there yet
    add_row(op_upd, 2, '0, '0, '0, none, 0, 0, none);
    add_row(op_chk, none, 30'h200, 4'h3, '0, none, 1, 0, 2);
    add_row(op_chk, none, 30'h200, 4'hf, '0, none, 0, 1, none);
    add_row(op_chk, none, 30'h300, 4'hf, '0, none, 0, 0, none);
    add_row(op_wrt, 3, 30'h300, 4'hf, '0, none, 0, 0, none);
    add_row(op_upd, 3, '0, '0, 32'h2468_ace0, none, 0, 0, none);
    add_row(op_chk, none, 30'h300, 4'hf, '0, 3, 0, 0, none); // s3 not older than load
    add_row(op_chk, none, 30'h300, 4'hc, '0, none, 1, 0, 3);
    for (int k = 0; k < 4; k++) begin
      add_row(op_commit, none, '0, '0, '0, none, 0, 0, none);
    end
    add_row(op_fence, none, '0, '0, '0, none, 0, 0, none);
    // fill all 16 entries
    for (int k = 4; k < 20; k++) begin
      add_row(op_alloc, 8'(k), '0, '0, '0, none, 0, 0, none);
    end
    add_row(op_rdy, none, '0, '0, '0, none, 0, 0, none);
    add_row(op_wrt, 4, 30'h40, 4'hf, '0, none, 0, 0, none);
    add_row(op_upd, 4, '0, '0, '0, none, 0, 0, none);
    add_row(op_wrt, 5, 30'h41, 4'h1, '0, none, 0, 0, none);
    add_row(op_upd, 5, '0, '0, 32'h0000_00a5, none, 0, 0, none);
    add_row(op_commit, none, '0, '0, '0, none, 0, 0, none);
    add_row(op_commit, none, '0, '0, '0, none, 0, 0, none);
    add_row(op_wait, none, '0, '0, '0, none, 0, 0, none);
    add_row(op_alloc, 20, '0, '0, '0, none, 0, 0, none);
    add_row(op_wrt, 10, 30'h500, 4'hf, '0, none, 0, 0, none);
    add_row(op_upd, 10, '0, '0, '0, none, 0, 0, none);
    add_row(op_chk, none, 30'h500, 4'hf, '0, none, 1, 0, 10);
    add_row(op_excpt, none, '0, '0, '0, none, 0, 0, none);
    add_row(op_fence, none, '0, '0, '0, none, 0, 0, none);
    // reuse the flushed slots, stale s10 must stay dead
    for (int k = 21; k < 26; k++) begin
      add_row(op_alloc, 8'(k), '0, '0, '0, none, 0, 0, none);
    end
    add_row(op_chk, none, 30'h500, 4'hf, '0, none, 0, 0, none);
    add_row(op_wrt, 21, 30'h700, 4'hf, '0, none, 0, 0, none);
    add_row(op_upd, 21, '0, '0, '0, none, 0, 0, none);
    add_row(op_wrt, 25, 30'h700, 4'h3, '0, none, 0, 0, none);
    add_row(op_upd, 25, '0, '0, '0, none, 0, 0, none);
    add_row(op_chk, none, 30'h700, 4'hf, '0, none, 0, 1, none);
    add_row(op_commit, none, '0, '0, '0, none, 0, 0, none); // s21 still queued at the flush
    add_row(op_excpt, none, '0, '0, '0, none, 0, 0, none);
    add_row(op_fence, none, '0, '0, '0, none, 0, 0, none);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #10;
    wb_ready = (rand_bits(1) != 0);
  endtask

  task automatic clear_inputs();
    alloc_en = 1'b0;
    wrt_en = 1'b0;
    upd_en = 1'b0;
    chk_en = 1'b0;
    commit_en = 1'b0;
    excpt = 1'b0;
    fence_req = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    int wait_n;
    int sid;
    wait_n = 0;
    next_cycle();
    clear_inputs();
    case (r.op)
      op_alloc: begin
        logic_compare("alloc_rdy", alloc_rdy, 1'b1);
        ptr_compare("alloc_ptr", alloc_ptr, m_tail);
        st_ptr[r.sid] = m_tail;
        pend_q.push_back(r.sid);
        m_tail = m_tail + 1'b1;
        alloc_en = 1'b1;
      end
      op_wrt: begin
        st_addr[r.sid] = r.addr;
        st_be[r.sid] = r.be;
        wrt_en = 1'b1;
        wrt_idx = st_ptr[r.sid][`STQ_IDX_W-1:0];
        wrt_addr = r.addr;
        wrt_be = r.be;
      end
      op_upd: begin
        st_data[r.sid] = (r.data != '0) ? r.data : rand_bits(32);
        upd_en = 1'b1;
        upd_idx = st_ptr[r.sid][`STQ_IDX_W-1:0];
        upd_data = st_data[r.sid];
      end
      op_commit: begin
        sid = pend_q.pop_front();
        wb_q.push_back(sid);
        m_commit = m_commit + 1'b1;
        commit_en = 1'b1;
      end
      op_chk: begin
        chk_en = 1'b1;
        chk_addr = r.addr;
        chk_be = r.be;
        chk_ptr = (r.psid == none) ? m_tail : st_ptr[r.psid];
        due_q.push_back(cyc + 1); // result one cycle after the sampling edge
        exp_hit_q.push_back(r.eh);
        exp_part_q.push_back(r.ep);
        exp_data_q.push_back(r.eh ? st_data[r.esid] : '0);
      end
      op_excpt: begin
        excpt = 1'b1;
        pend_q.delete();
        m_tail = m_commit;
      end
      op_fence: begin
        fence_req = 1'b1;
        @(negedge clk);
        while (!fence_done && wait_n < 200) begin
          next_cycle();
          @(negedge clk);
          wait_n++;
        end
        if (!fence_done) begin
          n_other++;
          $display("fence_done never pulsed for a fence request at %0t", $time);
        end else if (wb_q.size() != 0 || pend_q.size() != 0) begin
          n_other++;
          $display("fence_done pulsed before the queue drained at %0t", $time);
        end
      end
      op_rdy: begin
        logic_compare("alloc_rdy", alloc_rdy, r.eh);
      end
      op_wait: begin
        while (!alloc_rdy && wait_n < 200) begin
          next_cycle();
          wait_n++;
        end
        if (!alloc_rdy) begin
          n_other++;
          $display("alloc_rdy did not rise after a drain transfer at %0t", $time);
        end
      end
      default: begin
        n_other++;
        $display("table row has an unknown operation");
      end
    endcase
  endtask

  // write-back, forward and fence checks, mid-cycle
  always @(negedge clk) begin : monitor
    int sid;
    if (!rst) begin
      if (held) begin
        logic_compare("wb_valid", wb_valid, 1'b1);
        addr_compare("wb_addr", wb_addr, held_addr);
        be_compare("wb_be", wb_be, held_be);
        data_compare("wb_data", wb_data, held_data);
      end
      held = wb_valid && !wb_ready;
      held_addr = wb_addr;
      held_be = wb_be;
      held_data = wb_data;
      if (wb_valid && wb_ready) begin
        if (wb_q.size() == 0) begin
          n_other++;
          $display("write-back transfer with no committed store left at %0t", $time);
        end else begin
          sid = wb_q.pop_front();
          addr_compare("wb_addr", wb_addr, st_addr[sid]);
          be_compare("wb_be", wb_be, st_be[sid]);
          data_compare("wb_data", wb_data, st_data[sid]);
        end
      end
      if (due_q.size() != 0 && due_q[0] == cyc) begin
        logic_compare("fwd_valid", fwd_valid, 1'b1);
        logic_compare("fwd_hit", fwd_hit, exp_hit_q.pop_front());
        logic_compare("fwd_partial", fwd_partial, exp_part_q.pop_front());
        data_compare("fwd_data", fwd_data, exp_data_q.pop_front());
        sid = due_q.pop_front();
      end else begin
        logic_compare("fwd_valid", fwd_valid, 1'b0);
      end
      if (fence_done && !fence_req) begin
        n_other++;
        $display("fence_done pulsed without a fence request at %0t", $time);
      end
    end
  end

  initial begin
    rst = 1'b1;
    clear_inputs();
    wrt_idx = '0;
    wrt_addr = '0;
    wrt_be = '0;
    upd_idx = '0;
    upd_data = '0;
    chk_addr = '0;
    chk_be = '0;
    chk_ptr = '0;
    wb_ready = 1'b0;
    held = 1'b0;
    m_tail = '0;
    m_commit = '0;
    lfsr = 16'd41569;
    build_table();
    limit = rows.size() * 20 + `STQ_DEPTH * 20;
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    next_cycle();
    clear_inputs();
    repeat (3) next_cycle();
    if (due_q.size() != 0) begin
      n_other++;
      $display("a load check got no forward result");
    end
    $display("errors: %0d value mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    wait (limit != 0);
    repeat (limit) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hw
hw/stq_pkg.sv
hw/stq_ptr_ctr.sv
hw/stq_drain_fsm.sv
hw/stq_addr_cam.sv
hw/stq_data_ram.sv
hw/stq_fwd_select.sv
hw/stq_top.sv
verif/stq_tb.sv
